//--- aligner/instr_aligner.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module instr_aligner (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 fetch_valid_i,
  input  bus_pkg::fetch_word_t fetch_rdata_i,
  output logic                 fetch_pop_o,
  output logic                 raw_hold_o,
  input  logic                 id_valid_i,
  input  logic                 hold_state_i,
  input  logic                 branch_i,
  input  logic                 branch_is_jump_i,
  input  bus_pkg::addr_t       branch_addr_i,
  output instr_pkg::instr_t    instr_o,
  output logic                 instr_valid_o,
  output bus_pkg::addr_t       pc_o
);

  localparam bus_pkg::addr_t BOOT_ADDR = `FETCH_BOOT_ADDR;

  instr_pkg::align_state_e state_q;
  instr_pkg::align_state_e state_d;
  instr_pkg::half_t        fetch_lo;
  instr_pkg::half_t        fetch_hi;
  instr_pkg::half_t        saved_h_q;
  instr_pkg::half_t        saved_l_q;
  bus_pkg::addr_t          pc_q;
  bus_pkg::addr_t          pc_d;
  bus_pkg::addr_t          pc_plus2;
  bus_pkg::addr_t          pc_plus4;
  bus_pkg::addr_t          jump_target_q;
  logic                    jump_valid_q;
  logic                    advance;
  logic                    consume;
  logic                    jump_stall;

  assign fetch_lo = fetch_rdata_i[15:0];
  assign fetch_hi = fetch_rdata_i[31:16];
  assign pc_plus2 = pc_q + 32'd2;
  assign pc_plus4 = pc_q + 32'd4;
  assign pc_o     = pc_q;

  // ID takes the instruction when it is valid and not holding the pc
  assign advance = id_valid_i && !hold_state_i;

  // a jump sitting in a stalled ID must survive the redirect
  assign jump_stall = branch_i && branch_is_jump_i && !id_valid_i;

  ////////////////////
  // next state and instruction
  ////////////////////

  always_comb begin
    pc_d          = pc_q;
    state_d       = state_q;
    instr_o       = fetch_rdata_i;
    instr_valid_o = fetch_valid_i;
    raw_hold_o    = 1'b0;
    consume       = 1'b0;

    case (state_q)
      instr_pkg::aligned32: begin
        // the word starts on a boundary and its low parcel decides the size
        consume = fetch_valid_i && advance;
        if (fetch_lo[1:0] == 2'b11) begin
          state_d = instr_pkg::aligned32;
          pc_d    = pc_plus4;
        end else begin
          state_d = instr_pkg::aligned16;
          pc_d    = pc_plus2;
        end
      end

      instr_pkg::aligned16, instr_pkg::misaligned32: begin
        // instruction begins in the upper parcel saved from the last word
        if (saved_h_q[1:0] == 2'b11) begin
          // a 32-bit instruction takes its upper half from the head word
          instr_o = {fetch_lo, saved_h_q};
          state_d = instr_pkg::misaligned32;
          pc_d    = pc_plus4;
          consume = fetch_valid_i && advance;
        end else begin
          // a compressed one is complete and valid even with an empty queue
          instr_o       = {fetch_hi, saved_h_q};
          instr_valid_o = 1'b1;
          state_d       = instr_pkg::misaligned16;
          pc_d          = pc_plus2;
          // the head word is untouched so far so the buffer keeps it
          raw_hold_o    = fetch_valid_i;
          consume       = advance;
        end
      end

      instr_pkg::misaligned16: begin
        // the word kept by raw_hold is still at the head of the queue
        consume = fetch_valid_i && advance;
        if (fetch_lo[1:0] == 2'b11) begin
          state_d = instr_pkg::aligned32;
          pc_d    = pc_plus4;
        end else begin
          state_d = instr_pkg::aligned16;
          pc_d    = pc_plus2;
        end
      end

      instr_pkg::branch_misaligned: begin
        // the target is the upper parcel and the low one belongs to the old path
        consume = fetch_valid_i && advance;
        if (fetch_hi[1:0] == 2'b11) begin
          // only half of a 32-bit instruction is here so nothing is offered yet
          instr_valid_o = 1'b0;
          state_d       = instr_pkg::misaligned32;
          pc_d          = pc_q;
        end else begin
          instr_o = {fetch_hi, fetch_hi};
          state_d = instr_pkg::aligned32;
          pc_d    = pc_plus2;
        end
      end

      instr_pkg::wait_valid_branch: begin
        // replay the saved jump until ID accepts it and then go to its target
        instr_o       = {saved_h_q, saved_l_q};
        instr_valid_o = jump_valid_q;
        consume       = id_valid_i;
        pc_d          = jump_target_q;
        state_d       = jump_target_q[1] ? instr_pkg::branch_misaligned
                                         : instr_pkg::aligned32;
      end

      default: begin
        // unused encodings fall back to a word boundary
        instr_valid_o = 1'b0;
        consume       = 1'b1;
        state_d       = instr_pkg::aligned32;
      end
    endcase

    // redirect overrides whatever the state wanted
    if (branch_i) begin
      consume    = 1'b1;
      raw_hold_o = 1'b0;
      if (jump_stall) begin
        // pc stays on the jump while the target is kept aside
        pc_d    = pc_q;
        state_d = instr_pkg::wait_valid_branch;
      end else begin
        // the instruction in ID is done or dropped so fetch restarts at the target
        pc_d    = branch_addr_i;
        state_d = branch_addr_i[1] ? instr_pkg::branch_misaligned
                                   : instr_pkg::aligned32;
      end
    end
  end

  // pop only a word that was really used
  // the queue is flushed by the branch itself and refills at the target
  // while a saved jump waits
  assign fetch_pop_o = consume && fetch_valid_i && !raw_hold_o && !branch_i &&
                       (state_q != instr_pkg::wait_valid_branch);

  ////////////////////
  // registers
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= BOOT_ADDR[1] ? instr_pkg::branch_misaligned
                                   : instr_pkg::aligned32;
      pc_q         <= BOOT_ADDR;
      jump_valid_q <= 1'b0;
    end else if (consume) begin
      state_q <= state_d;
      pc_q    <= pc_d;
      if (jump_stall) begin
        jump_valid_q <= instr_valid_o;
      end
    end
  end

  // the saved parcels and the jump target load on a consuming cycle
  always_ff @(posedge clk) begin
    if (consume) begin
      if (jump_stall) begin
        // the high parcel register doubles as storage for the jump
        saved_h_q     <= instr_o[31:16];
        saved_l_q     <= instr_o[15:0];
        jump_target_q <= branch_addr_i;
      end else begin
        saved_h_q <= fetch_hi;
      end
    end
  end

endmodule

//--- common/bus_pkg.sv
package bus_pkg;

  ////////////////////
  // memory side types
  ////////////////////

  // byte address, fetch requests only ever use word aligned values
  typedef logic [31:0] addr_t;

  // one word as returned by instruction memory
  typedef logic [31:0] fetch_word_t;

  // tag attached to each granted request
  // the current epoch flips on a branch, so responses for the old path
  // carry a tag that no longer matches and get dropped
  typedef logic epoch_t;

endpackage

//--- common/fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////
// fetch front end sizing
////////////////////

// number of words the prefetch queue can hold
// keep it a power of two, the FIFO pointers wrap naturally
`define FETCH_FIFO_DEPTH 4

// granted requests that may still be waiting for their response
// this is also the depth of the epoch tag queue
`define FETCH_MAX_OUTSTANDING 2

////////////////////
// reset values
////////////////////

// pc after reset and the first word fetched
// a halfword boot address starts the aligner in branch_misaligned
`define FETCH_BOOT_ADDR 32'h0000_0000

`endif

//--- common/instr_pkg.sv
package instr_pkg;

  ////////////////////
  // instruction side types
  ////////////////////

  // one 16-bit parcel, the unit the aligner works in
  typedef logic [15:0] half_t;

  // an instruction handed to ID, always 32 bits wide
  // a compressed instruction sits in the low half, the high half is don't care
  typedef logic [31:0] instr_t;

  // where the next instruction starts relative to the head word
  // aligned32 and misaligned16 take the low parcel of a fresh word
  // aligned16 and misaligned32 start in the saved upper parcel
  // branch_misaligned waits for the word that holds a halfword target
  // wait_valid_branch keeps a jump alive while ID is stalled
  typedef enum logic [2:0] {
    aligned32,
    aligned16,
    misaligned32,
    misaligned16,
    branch_misaligned,
    wait_valid_branch
  } align_state_e;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  output logic                 mem_req_o,
  output bus_pkg::addr_t       mem_addr_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  bus_pkg::fetch_word_t mem_rdata_i,
  input  logic                 branch_i,
  input  logic                 branch_is_jump_i,
  input  bus_pkg::addr_t       branch_addr_i,
  input  logic                 id_valid_i,
  input  logic                 hold_state_i,
  output instr_pkg::instr_t    instr_o,
  output logic                 instr_valid_o,
  output bus_pkg::addr_t       pc_o
);

  ////////////////////
  // buffer to aligner
  ////////////////////

  logic                 fetch_valid;
  bus_pkg::fetch_word_t fetch_rdata;
  logic                 fetch_pop;

  // both blocks see the branch in the same cycle
  prefetch_buffer i_prefetch_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_gnt_i     (mem_gnt_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i),
    .pop_i         (fetch_pop),
    .fetch_valid_o (fetch_valid),
    .fetch_rdata_o (fetch_rdata)
  );

  // raw_hold is already folded into fetch_pop inside the aligner
  instr_aligner i_instr_aligner (
    .clk              (clk),
    .rst_n            (rst_n),
    .fetch_valid_i    (fetch_valid),
    .fetch_rdata_i    (fetch_rdata),
    .fetch_pop_o      (fetch_pop),
    .raw_hold_o       (),
    .id_valid_i       (id_valid_i),
    .hold_state_i     (hold_state_i),
    .branch_i         (branch_i),
    .branch_is_jump_i (branch_is_jump_i),
    .branch_addr_i    (branch_addr_i),
    .instr_o          (instr_o),
    .instr_valid_o    (instr_valid_o),
    .pc_o             (pc_o)
  );

endmodule

//--- prefetch/fetch_fifo.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = `FETCH_FIFO_DEPTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   flush_i,
  input  logic                   push_i,
  input  payload_t               data_i,
  input  logic                   pop_i,
  output payload_t               data_o,
  output logic                   empty_o,
  output logic                   full_o,
  output logic [$clog2(DEPTH):0] count_o
);

  localparam int unsigned PTR_W = $clog2(DEPTH);

  // storage has no reset, an entry is only read after it was written
  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;

  // head entry is visible without a pop, the consumer peeks at it
  assign data_o  = mem[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
  assign count_o = count_q;

  ////////////////////
  // pointers and occupancy
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // flush wins over a push or pop in the same cycle
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      // a push together with a pop leaves the count as it is
      if (push_i && !pop_i) begin
        count_q <= count_q + (PTR_W + 1)'(1);
      end else if (pop_i && !push_i) begin
        count_q <= count_q - (PTR_W + 1)'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push_i && !flush_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- prefetch/prefetch_buffer.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module prefetch_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 branch_i,
  input  bus_pkg::addr_t       branch_addr_i,
  output logic                 mem_req_o,
  output bus_pkg::addr_t       mem_addr_o,
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  bus_pkg::fetch_word_t mem_rdata_i,
  input  logic                 pop_i,
  output logic                 fetch_valid_o,
  output bus_pkg::fetch_word_t fetch_rdata_o
);

  localparam bus_pkg::addr_t BOOT_ADDR  = `FETCH_BOOT_ADDR;
  localparam int unsigned    WORD_CNT_W = $clog2(`FETCH_FIFO_DEPTH) + 1;
  localparam int unsigned    TAG_CNT_W  = $clog2(`FETCH_MAX_OUTSTANDING) + 1;

  bus_pkg::addr_t        addr_q;
  bus_pkg::addr_t        redirect_addr_q;
  bus_pkg::addr_t        target_word;
  bus_pkg::epoch_t       epoch_q;
  bus_pkg::epoch_t       tag_head;
  bus_pkg::epoch_t       grant_tag;
  logic                  req_wait_q;
  logic                  stale_req_q;
  logic                  word_empty;
  logic                  tag_empty;
  logic                  tag_full;
  logic [WORD_CNT_W-1:0] word_count;
  logic [TAG_CNT_W-1:0]  tag_count;
  logic [31:0]           in_flight;
  logic                  stale_pending;
  logic                  stale_any;
  logic                  can_req;
  logic                  grant;
  logic                  rsp_good;

  assign target_word = {branch_addr_i[31:2], 2'b00};

  ////////////////////
  // request side
  ////////////////////

  // words queued plus words still on the bus must fit in the queue,
  // so a response always finds room even while the aligner stalls
  assign in_flight = 32'(word_count) + 32'(tag_count);

  // responses come back in order, so the oldest tag tells us whether
  // the old path is still draining
  assign stale_pending = !tag_empty && (tag_head != epoch_q);
  assign stale_any     = stale_pending || stale_req_q;

  // no request while reset is asserted
  // no new request while old path responses are out either, otherwise a
  // second branch would flip the 1-bit epoch back onto them
  assign can_req = rst_n && (in_flight < 32'(`FETCH_FIFO_DEPTH)) && !tag_full &&
                   !stale_pending && !branch_i;

  // once raised the request stays up with its address until granted
  assign mem_req_o  = req_wait_q || can_req;
  assign mem_addr_o = addr_q;
  assign grant      = mem_req_o && mem_gnt_i;

  // a request caught by a branch before its grant still goes out
  // and is tagged with the other epoch so its word is thrown away
  assign grant_tag = stale_req_q ? ~epoch_q : epoch_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q      <= {BOOT_ADDR[31:2], 2'b00};
      epoch_q     <= '0;
      req_wait_q  <= 1'b0;
      stale_req_q <= 1'b0;
    end else begin
      req_wait_q <= mem_req_o && !mem_gnt_i;
      // everything in flight is either all current or all stale
      // and only the first case needs a new epoch
      if (branch_i && !stale_any) begin
        epoch_q <= ~epoch_q;
      end
      if (branch_i) begin
        if (mem_req_o && !mem_gnt_i) begin
          // the address must hold so the target is picked up after the grant
          stale_req_q <= 1'b1;
        end else begin
          addr_q      <= target_word;
          stale_req_q <= 1'b0;
        end
      end else if (grant) begin
        addr_q      <= stale_req_q ? redirect_addr_q : addr_q + 32'd4;
        stale_req_q <= 1'b0;
      end
    end
  end

  // target kept for a redirect that has to wait for a grant
  always_ff @(posedge clk) begin
    if (branch_i) begin
      redirect_addr_q <= target_word;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  // a word arriving in the branch cycle belongs to the old path as well
  assign rsp_good = mem_rvalid_i && (tag_head == epoch_q) && !branch_i;

  fetch_fifo #(
    .payload_t (bus_pkg::epoch_t),
    .DEPTH     (`FETCH_MAX_OUTSTANDING)
  ) i_tag_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (1'b0),
    .push_i  (grant),
    .data_i  (grant_tag),
    .pop_i   (mem_rvalid_i),
    .data_o  (tag_head),
    .empty_o (tag_empty),
    .full_o  (tag_full),
    .count_o (tag_count)
  );

  fetch_fifo #(
    .payload_t (bus_pkg::fetch_word_t),
    .DEPTH     (`FETCH_FIFO_DEPTH)
  ) i_word_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .flush_i (branch_i),
    .push_i  (rsp_good),
    .data_i  (mem_rdata_i),
    .pop_i   (pop_i),
    .data_o  (fetch_rdata_o),
    .empty_o (word_empty),
    .full_o  (),
    .count_o (word_count)
  );

  assign fetch_valid_o = !word_empty;

endmodule

//--- sources.f
+incdir+common
common/instr_pkg.sv
common/bus_pkg.sv
prefetch/fetch_fifo.sv
prefetch/prefetch_buffer.sv
aligner/instr_aligner.sv
hdl/fetch_stage.sv
verif/fetch_clkgen.sv
verif/fetch_props.sv
verif/fetch_tb.sv

//--- verif/fetch_clkgen.sv
`timescale 1ns/1ps

module fetch_clkgen (
  output logic clk_o
);

  // 8 ns period, low for the first half
  initial begin
    clk_o = 1'b0;
  end

  always begin
    #4 clk_o = ~clk_o;
  end

endmodule

//--- verif/fetch_props.sv
`timescale 1ns/1ps
`include "fetch_consts.svh"

module fetch_props (
  input logic        clk,
  input logic        rst_n,
  input logic        mem_req_o,
  input logic [31:0] mem_addr_o,
  input logic        mem_gnt_i,
  input logic        mem_rvalid_i,
  input logic        branch_i,
  input logic        branch_is_jump_i,
  input logic [31:0] branch_addr_i,
  input logic        id_valid_i,
  input logic        hold_state_i,
  input logic [31:0] instr_o,
  input logic        instr_valid_o,
  input logic [31:0] pc_o
);

  // number of assertion failures so far
  int          err_cnt = 0;
  int          outstanding;
  logic        jump_pend;
  logic        jump_valid;
  logic [31:0] jump_instr;
  logic [31:0] jump_pc;
  logic [31:0] jump_target;
  logic        target_pend;
  logic [31:0] target_q;
  logic        accept;

  // the halfword at byte address a starts a 32-bit instruction
  function automatic logic wide_at(input logic [31:0] a);
    return a[2] ^ a[4] ^ a[6];
  endfunction

  // halfword content of instruction memory at byte address a
  function automatic logic [15:0] mem_half(input logic [31:0] a);
    return {a[14:1], wide_at(a) ? 2'b11 : 2'b00};
  endfunction

  assign accept = instr_valid_o && id_valid_i && !hold_state_i;

  ////////////////////
  // reference tracking
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding <= 0;
      jump_pend   <= 1'b0;
      jump_valid  <= 1'b0;
      target_pend <= 1'b0;
    end else begin
      outstanding <= outstanding + int'(mem_req_o && mem_gnt_i) - int'(mem_rvalid_i);
      if (branch_i && branch_is_jump_i && !id_valid_i) begin
        // the stalled instruction must be replayed as it is now
        jump_pend   <= 1'b1;
        jump_valid  <= instr_valid_o;
        jump_instr  <= instr_o;
        jump_pc     <= pc_o;
        jump_target <= branch_addr_i;
        target_pend <= 1'b0;
      end else if (branch_i) begin
        target_pend <= 1'b1;
        target_q    <= branch_addr_i;
      end else if (jump_pend && id_valid_i) begin
        // once the jump is taken its target is the next expected pc
        jump_pend   <= 1'b0;
        target_pend <= 1'b1;
        target_q    <= jump_target;
      end else if (instr_valid_o) begin
        target_pend <= 1'b0;
      end
    end
  end

  ////////////////////
  // instruction content
  ////////////////////

  low_parcel: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o |-> instr_o[15:0] == mem_half(pc_o))
    else begin
      $error("error: instr_o[15:0] %h expected %h at pc_o %h",
             instr_o[15:0], mem_half(pc_o), pc_o);
      err_cnt++;
    end

  high_parcel: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && instr_o[1:0] == 2'b11 |-> instr_o[31:16] == mem_half(pc_o + 32'd2))
    else begin
      $error("error: instr_o[31:16] %h expected %h at pc_o %h",
             instr_o[31:16], mem_half(pc_o + 32'd2), pc_o);
      err_cnt++;
    end

  ////////////////////
  // program counter
  ////////////////////

  // step size comes from the memory halfword at the accepted pc
  seq_pc: assert property (@(posedge clk) disable iff (!rst_n)
    accept && !branch_i && !jump_pend |=>
      pc_o == $past(pc_o) + (wide_at($past(pc_o)) ? 32'd4 : 32'd2))
    else begin
      $error("error: pc_o %h after sequential step from %h", pc_o, $past(pc_o));
      err_cnt++;
    end

  stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !accept && !branch_i && !jump_pend |=>
      instr_valid_o && instr_o[15:0] == $past(instr_o[15:0]) && pc_o == $past(pc_o))
    else begin
      $error("error: instr_o %h pc_o %h changed during stall", instr_o, pc_o);
      err_cnt++;
    end

  stall_stable_hi: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && instr_o[1:0] == 2'b11 && !accept && !branch_i && !jump_pend |=>
      instr_o == $past(instr_o))
    else begin
      $error("error: instr_o %h expected %h during stall", instr_o, $past(instr_o));
      err_cnt++;
    end

  branch_target: assert property (@(posedge clk) disable iff (!rst_n)
    target_pend && instr_valid_o |-> pc_o == target_q)
    else begin
      $error("error: pc_o %h expected branch target %h", pc_o, target_q);
      err_cnt++;
    end

  ////////////////////
  // jump under stall
  ////////////////////

  jump_replay: assert property (@(posedge clk) disable iff (!rst_n)
    jump_pend && jump_valid |->
      instr_valid_o && pc_o == jump_pc && instr_o[15:0] == jump_instr[15:0] &&
      (jump_instr[1:0] != 2'b11 || instr_o[31:16] == jump_instr[31:16]))
    else begin
      $error("error: instr_o %h pc_o %h expected held jump %h at %h",
             instr_o, pc_o, jump_instr, jump_pc);
      err_cnt++;
    end

  jump_taken: assert property (@(posedge clk) disable iff (!rst_n)
    jump_pend && id_valid_i |=> pc_o == $past(jump_target))
    else begin
      $error("error: pc_o %h expected jump target %h", pc_o, $past(jump_target));
      err_cnt++;
    end

  ////////////////////
  // bus and reset
  ////////////////////

  reset_idle: assert property (@(posedge clk)
    !rst_n |-> !mem_req_o && !instr_valid_o && pc_o == `FETCH_BOOT_ADDR)
    else begin
      $error("error: mem_req_o %h instr_valid_o %h pc_o %h in reset",
             mem_req_o, instr_valid_o, pc_o);
      err_cnt++;
    end

  addr_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |-> mem_addr_o[1:0] == 2'b00)
    else begin
      $error("error: mem_addr_o %h not word aligned", mem_addr_o);
      err_cnt++;
    end

  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_addr_o))
    else begin
      $error("error: mem_req_o %h mem_addr_o %h dropped before grant", mem_req_o, mem_addr_o);
      err_cnt++;
    end

  max_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    outstanding <= `FETCH_MAX_OUTSTANDING)
    else begin
      $error("error: outstanding %h above limit %h", outstanding, `FETCH_MAX_OUTSTANDING);
      err_cnt++;
    end

endmodule

//--- verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

  localparam int          NUM_CYCLES = 4000;
  localparam int          TIMEOUT_NS = (NUM_CYCLES + 500) * 8;
  localparam logic [31:0] SEED       = 32'h5fbe_f5dd;

  logic        clk;
  logic        rst_n;
  logic        mem_req_o;
  logic [31:0] mem_addr_o;
  logic        mem_gnt_i;
  logic        mem_rvalid_i;
  logic [31:0] mem_rdata_i;
  logic        branch_i;
  logic        branch_is_jump_i;
  logic [31:0] branch_addr_i;
  logic        id_valid_i;
  logic        hold_state_i;
  logic [31:0] instr_o;
  logic        instr_valid_o;
  logic [31:0] pc_o;

  logic [31:0] lfsr;
  logic [31:0] rsp_addr [$];
  int          rsp_due [$];
  int          cycle;
  int          consumed;
  logic        jump_wait;
  logic        granted;
  logic [31:0] grant_addr;

  fetch_clkgen i_clkgen (
    .clk_o (clk)
  );

  fetch_stage uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .mem_req_o        (mem_req_o),
    .mem_addr_o       (mem_addr_o),
    .mem_gnt_i        (mem_gnt_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .branch_i         (branch_i),
    .branch_is_jump_i (branch_is_jump_i),
    .branch_addr_i    (branch_addr_i),
    .id_valid_i       (id_valid_i),
    .hold_state_i     (hold_state_i),
    .instr_o          (instr_o),
    .instr_valid_o    (instr_valid_o),
    .pc_o             (pc_o)
  );

  bind fetch_stage fetch_props i_props (.*);

  // fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  // memory content, one halfword per byte address pair
  function automatic logic [15:0] half_at(input logic [31:0] a);
    return {a[14:1], (a[2] ^ a[4] ^ a[6]) ? 2'b11 : 2'b00};
  endfunction

  function automatic logic [31:0] word_at(input logic [31:0] a);
    return {half_at(a + 32'd2), half_at(a)};
  endfunction

  ////////////////////
  // memory model
  ////////////////////

  task automatic drive_memory(input logic gnt_seen, input logic [31:0] addr);
    logic [31:0] v;
    if (gnt_seen) begin
      draw_bits(2, v);
      rsp_addr.push_back(addr);
      // a delay of one cycle answers right after the grant edge
      rsp_due.push_back(cycle + int'(v % 3));
    end
    if (rsp_addr.size() != 0 && rsp_due[0] <= cycle) begin
      mem_rvalid_i = 1'b1;
      mem_rdata_i  = word_at(rsp_addr.pop_front());
      void'(rsp_due.pop_front());
    end else begin
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = 32'h0;
    end
    draw_bits(2, v);
    mem_gnt_i = (v != 0);
  endtask

  ////////////////////
  // ID side stimulus
  ////////////////////

  task automatic drive_id();
    logic [31:0] v;
    // a pending jump is taken once ID has been valid for a cycle
    if (jump_wait && id_valid_i) begin
      jump_wait = 1'b0;
    end
    draw_bits(2, v);
    id_valid_i = (v != 0);
    draw_bits(3, v);
    hold_state_i = (v == 0);
    branch_i         = 1'b0;
    branch_is_jump_i = 1'b0;
    if (!jump_wait) begin
      draw_bits(4, v);
      if (v == 0) begin
        draw_bits(13, v);
        branch_i      = 1'b1;
        branch_addr_i = {18'h0, v[12:0], 1'b0};
        draw_bits(1, v);
        branch_is_jump_i = v[0];
        jump_wait        = branch_is_jump_i && !id_valid_i;
      end
    end
  endtask

  initial begin
    lfsr             = SEED;
    rst_n            = 1'b0;
    mem_gnt_i        = 1'b0;
    mem_rvalid_i     = 1'b0;
    mem_rdata_i      = 32'h0;
    branch_i         = 1'b0;
    branch_is_jump_i = 1'b0;
    branch_addr_i    = 32'h0;
    id_valid_i       = 1'b1;
    hold_state_i     = 1'b0;
    jump_wait        = 1'b0;
    consumed         = 0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    for (cycle = 0; cycle < NUM_CYCLES; cycle++) begin
      // inputs are quiet since the last drive, so outputs are settled here
      @(negedge clk);
      granted    = mem_req_o && mem_gnt_i;
      grant_addr = mem_addr_o;
      if (instr_valid_o && id_valid_i && !hold_state_i) begin
        consumed++;
      end
      @(posedge clk);
      #1;
      drive_memory(granted, grant_addr);
      drive_id();
    end
    if (uut.i_props.err_cnt != 0 || consumed == 0) begin
      $display("Test failed");
      $fatal(1, "run ended with failed checks or without any accepted instruction");
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

  // stop at the first assertion failure
  always @(negedge clk) begin
    if (uut.i_props.err_cnt != 0) begin
      $display("Test failed");
      $fatal(1, "an assertion in fetch_props failed");
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired before the stimulus finished");
  end

endmodule
